// ==== src/dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

  // Memory line geometry
  localparam int DATA_WIDTH      = 64;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int LINE_ADDR_BITS  = $clog2(STRB_WIDTH);

  // The core and the broadcast path work on 32-bit lanes
  localparam int LANE_WIDTH      = 32;
  localparam int LANE_STRB       = LANE_WIDTH / 8;

  // Data memory, split into two banks by the address bit above the byte offset
  localparam int DMEM_SIZE       = 4096;
  localparam int DMEM_ADDR_WIDTH = $clog2(DMEM_SIZE);
  localparam int BANK_ADDR_WIDTH = DMEM_ADDR_WIDTH - LINE_ADDR_BITS - 1;

  // Broadcast region sits at the top of data memory
  localparam int BC_REGION_SIZE  = 512;
  localparam int BC_START_ADDR   = DMEM_SIZE - BC_REGION_SIZE;
  localparam int MSG_ADDR_WIDTH  = $clog2(BC_REGION_SIZE) - 2;

  // Message layout is {word index, strobe, data}
  localparam int MSG_WIDTH       = MSG_ADDR_WIDTH + LANE_STRB + LANE_WIDTH;

  // Queue depths
  localparam int CMD_FIFO_DEPTH  = 4;
  localparam int RESP_FIFO_DEPTH = 8;
  localparam int RESP_CNT_WIDTH  = $clog2(RESP_FIFO_DEPTH + 1);

  // One memory line, seen either as a whole or as two lanes.
  // Lane 0 is the low half
  typedef union packed {
    logic [DATA_WIDTH-1:0]         word;
    logic [1:0][LANE_WIDTH-1:0]    lane;
  } mem_line_t;

endpackage

`default_nettype wire

// ==== src/bank_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bank_req_if
  import dmem_pkg::*;
();

  // Head of the DMA write queue
  logic                       wr_valid;
  logic [DMEM_ADDR_WIDTH-1:0] wr_addr;
  logic [STRB_WIDTH-1:0]      wr_strb;
  logic [DATA_WIDTH-1:0]      wr_data;
  logic                       wr_ready;

  // Head of the DMA read queue
  logic                       rd_valid;
  logic [DMEM_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_ready;

  modport decode (
    output wr_valid, wr_addr, wr_strb, wr_data, rd_valid, rd_addr,
    input  wr_ready, rd_ready
  );

  modport execute (
    input  wr_valid, wr_addr, wr_strb, wr_data, rd_valid, rd_addr,
    output wr_ready, rd_ready
  );

endinterface

`default_nettype wire

// ==== src/req_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module req_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire                           clk,
  input  wire                           rst,

  input  wire                           din_valid,
  input  wire  [WIDTH-1:0]              din,
  output logic                          din_ready,

  output logic                          dout_valid,
  output logic [WIDTH-1:0]              dout,
  input  wire                           dout_ready,

  output logic [$clog2(DEPTH+1)-1:0]    count
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     push;
  logic                     pop;

  assign din_ready  = (count != DEPTH);
  assign dout_valid = (count != 0);
  assign dout       = mem[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the occupancy unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_cmd_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_cmd_decode
  import dmem_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,

  input  wire                        dma_wr_valid,
  input  wire  [DMEM_ADDR_WIDTH-1:0] dma_wr_addr,
  input  wire  [STRB_WIDTH-1:0]      dma_wr_strb,
  input  wire  [DATA_WIDTH-1:0]      dma_wr_data,
  output logic                       dma_wr_ready,

  input  wire                        dma_rd_valid,
  input  wire  [DMEM_ADDR_WIDTH-1:0] dma_rd_addr,
  output logic                       dma_rd_ready,

  bank_req_if.decode                 req
);

  //////////////////////////////
  // Write queue

  // Address, strobe and data of a write travel as one entry
  logic [DMEM_ADDR_WIDTH+STRB_WIDTH+DATA_WIDTH-1:0] wr_head;

  req_fifo #(
    .WIDTH(DMEM_ADDR_WIDTH + STRB_WIDTH + DATA_WIDTH),
    .DEPTH(CMD_FIFO_DEPTH)
  ) wr_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (dma_wr_valid),
    .din       ({dma_wr_addr, dma_wr_strb, dma_wr_data}),
    .din_ready (dma_wr_ready),
    .dout_valid(req.wr_valid),
    .dout      (wr_head),
    .dout_ready(req.wr_ready),
    .count     ()
  );

  assign {req.wr_addr, req.wr_strb, req.wr_data} = wr_head;

  //////////////////////////////
  // Read queue

  // Reads queue apart from writes, so a stalled read side does not hold
  // back writes waiting for a bank
  req_fifo #(
    .WIDTH(DMEM_ADDR_WIDTH),
    .DEPTH(CMD_FIFO_DEPTH)
  ) rd_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (dma_rd_valid),
    .din       (dma_rd_addr),
    .din_ready (dma_rd_ready),
    .dout_valid(req.rd_valid),
    .dout      (req.rd_addr),
    .dout_ready(req.rd_ready),
    .count     ()
  );

endmodule

`default_nettype wire

// ==== src/dmem_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_bank
  import dmem_pkg::*;
(
  input  wire                        clk,

  input  wire                        a_en,
  input  wire  [STRB_WIDTH-1:0]      a_wen,
  input  wire  [BANK_ADDR_WIDTH-1:0] a_addr,
  input  wire  mem_line_t            a_wdata,
  output mem_line_t                  a_rdata,

  input  wire                        b_en,
  input  wire  [STRB_WIDTH-1:0]      b_wen,
  input  wire  [BANK_ADDR_WIDTH-1:0] b_addr,
  input  wire  mem_line_t            b_wdata,
  output mem_line_t                  b_rdata
);

  mem_line_t mem [2**BANK_ADDR_WIDTH];

  // Both ports read the old line on a write to the same address.
  // Port B is written last
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_rdata <= mem[a_addr];
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (a_wen[i]) begin
          mem[a_addr].word[8*i +: 8] <= a_wdata.word[8*i +: 8];
        end
      end
    end
    if (b_en) begin
      b_rdata <= mem[b_addr];
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (b_wen[i]) begin
          mem[b_addr].word[8*i +: 8] <= b_wdata.word[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/bank_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_execute
  import dmem_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,

  input  wire  [MSG_WIDTH-1:0]       msg,
  input  wire                        msg_valid,

  input  wire                        core_en,
  input  wire                        core_wen,
  input  wire  [LANE_STRB-1:0]       core_strb,
  input  wire  [DMEM_ADDR_WIDTH-1:0] core_addr,
  input  wire  [LANE_WIDTH-1:0]      core_wdata,
  output logic [LANE_WIDTH-1:0]      core_rdata,
  output logic                       core_rd_valid,

  bank_req_if.execute                req,

  input  wire                        rd_room,
  output logic                       rd_data_valid,
  output logic [DATA_WIDTH-1:0]      rd_data
);

  // Put a 32-bit word into one lane of an otherwise empty line
  function automatic mem_line_t place_word(
    input logic                  lane,
    input logic [LANE_WIDTH-1:0] data
  );
    mem_line_t line;
    line.word       = '0;
    line.lane[lane] = data;
    return line;
  endfunction

  // Move a lane strobe to the byte enables of the same lane
  function automatic logic [STRB_WIDTH-1:0] place_strb(
    input logic                 lane,
    input logic [LANE_STRB-1:0] strb
  );
    logic [STRB_WIDTH-1:0] line_strb;
    line_strb = '0;
    line_strb[LANE_STRB*lane +: LANE_STRB] = strb;
    return line_strb;
  endfunction

  //////////////////////////////
  // Broadcast messages

  logic [MSG_ADDR_WIDTH-1:0]  msg_idx;
  logic [DMEM_ADDR_WIDTH-1:0] bc_addr;
  logic [DMEM_ADDR_WIDTH-1:0] bc_addr_r;
  mem_line_t                  bc_line_r;
  logic [STRB_WIDTH-1:0]      bc_strb_r;
  logic                       bc_valid_r;

  assign msg_idx = msg[MSG_WIDTH-1 -: MSG_ADDR_WIDTH];
  assign bc_addr = DMEM_ADDR_WIDTH'(BC_START_ADDR) + DMEM_ADDR_WIDTH'({msg_idx, 2'b00});

  // The message is converted to a full line here, so the bank port only
  // sees a ready write in the following cycle
  always_ff @(posedge clk) begin
    bc_addr_r <= bc_addr;
    bc_line_r <= place_word(bc_addr[LINE_ADDR_BITS-1], msg[LANE_WIDTH-1:0]);
    bc_strb_r <= place_strb(bc_addr[LINE_ADDR_BITS-1], msg[LANE_WIDTH +: LANE_STRB]);
  end

  //////////////////////////////
  // Core port

  logic                  core_bank;
  logic                  core_lane;
  logic                  core_bank_r;
  logic                  core_lane_r;
  logic [1:0]            b_en;
  logic [STRB_WIDTH-1:0] core_line_strb;
  mem_line_t             core_line;
  mem_line_t             core_rline;
  mem_line_t             b_rdata [2];

  assign core_bank      = core_addr[LINE_ADDR_BITS];
  assign core_lane      = core_addr[LINE_ADDR_BITS-1];
  assign core_line      = place_word(core_lane, core_wdata);
  assign core_line_strb = core_wen ? place_strb(core_lane, core_strb) : '0;

  assign b_en[0] = core_en && !core_bank;
  assign b_en[1] = core_en && core_bank;

  // Bank and lane are kept to pick the returning word a cycle later
  always_ff @(posedge clk) begin
    core_bank_r <= core_bank;
    core_lane_r <= core_lane;
  end

  assign core_rline = core_bank_r ? b_rdata[1] : b_rdata[0];
  assign core_rdata = core_rline.lane[core_lane_r];

  //////////////////////////////
  // Shared port arbitration

  logic [1:0]                 a_en;
  logic [STRB_WIDTH-1:0]      a_wen   [2];
  logic [BANK_ADDR_WIDTH-1:0] a_addr  [2];
  mem_line_t                  a_wdata [2];
  mem_line_t                  a_rdata [2];
  logic [1:0]                 wr_gnt;
  logic [1:0]                 rd_gnt;
  logic                       rd_bank_r;

  // Broadcast first, then the queued write, then the queued read if the
  // response queue has room for it
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      a_en[b]    = 1'b0;
      a_wen[b]   = '0;
      a_addr[b]  = req.rd_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
      a_wdata[b] = req.wr_data;
      wr_gnt[b]  = 1'b0;
      rd_gnt[b]  = 1'b0;

      if (bc_valid_r && bc_addr_r[LINE_ADDR_BITS] == b[0]) begin
        a_en[b]    = 1'b1;
        a_wen[b]   = bc_strb_r;
        a_addr[b]  = bc_addr_r[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
        a_wdata[b] = bc_line_r;
      end else if (req.wr_valid && req.wr_addr[LINE_ADDR_BITS] == b[0]) begin
        a_en[b]    = 1'b1;
        a_wen[b]   = req.wr_strb;
        a_addr[b]  = req.wr_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
        wr_gnt[b]  = 1'b1;
      end else if (req.rd_valid && rd_room && req.rd_addr[LINE_ADDR_BITS] == b[0]) begin
        a_en[b]    = 1'b1;
        rd_gnt[b]  = 1'b1;
      end
    end
  end

  assign req.wr_ready = |wr_gnt;
  assign req.rd_ready = |rd_gnt;

  always_ff @(posedge clk) begin
    rd_bank_r <= rd_gnt[1];
  end

  assign rd_data = rd_bank_r ? a_rdata[1].word : a_rdata[0].word;

  always_ff @(posedge clk) begin
    if (rst) begin
      bc_valid_r    <= 1'b0;
      core_rd_valid <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      bc_valid_r    <= msg_valid;
      core_rd_valid <= core_en && !core_wen;
      rd_data_valid <= |rd_gnt;
    end
  end

  //////////////////////////////
  // Banks

  dmem_bank bank0 (
    .clk    (clk),
    .a_en   (a_en[0]),
    .a_wen  (a_wen[0]),
    .a_addr (a_addr[0]),
    .a_wdata(a_wdata[0]),
    .a_rdata(a_rdata[0]),
    .b_en   (b_en[0]),
    .b_wen  (core_line_strb),
    .b_addr (core_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1]),
    .b_wdata(core_line),
    .b_rdata(b_rdata[0])
  );

  dmem_bank bank1 (
    .clk    (clk),
    .a_en   (a_en[1]),
    .a_wen  (a_wen[1]),
    .a_addr (a_addr[1]),
    .a_wdata(a_wdata[1]),
    .a_rdata(a_rdata[1]),
    .b_en   (b_en[1]),
    .b_wen  (core_line_strb),
    .b_addr (core_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1]),
    .b_wdata(core_line),
    .b_rdata(b_rdata[1])
  );

endmodule

`default_nettype wire

// ==== src/read_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_result
  import dmem_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst,

  input  wire                       rd_data_valid,
  input  wire  [DATA_WIDTH-1:0]     rd_data,
  output logic                      rd_room,

  output logic                      dma_rd_resp_valid,
  output logic [DATA_WIDTH-1:0]     dma_rd_resp_data,
  input  wire                       dma_rd_resp_ready
);

  logic                      in_flight;
  logic [RESP_CNT_WIDTH-1:0] resp_count;
  logic [RESP_CNT_WIDTH-1:0] occupancy;

  // A read granted last cycle is on its way into the queue now, and that
  // is the only one that can be between grant and queue
  assign in_flight = rd_data_valid;
  assign occupancy = resp_count + RESP_CNT_WIDTH'(in_flight);

  // A new grant is only allowed while one more entry still fits, even if
  // the DMA engine takes nothing out meanwhile
  assign rd_room = (occupancy < RESP_CNT_WIDTH'(RESP_FIFO_DEPTH));

  // space is reserved at grant time so the push side never sees a full queue
  req_fifo #(
    .WIDTH(DATA_WIDTH),
    .DEPTH(RESP_FIFO_DEPTH)
  ) resp_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (rd_data_valid),
    .din       (rd_data),
    .din_ready (),
    .dout_valid(dma_rd_resp_valid),
    .dout      (dma_rd_resp_data),
    .dout_ready(dma_rd_resp_ready),
    .count     (resp_count)
  );

endmodule

`default_nettype wire

// ==== src/dmem_sys_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_sys_top
  import dmem_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,

  input  wire                        dma_wr_valid,
  input  wire  [DMEM_ADDR_WIDTH-1:0] dma_wr_addr,
  input  wire  [STRB_WIDTH-1:0]      dma_wr_strb,
  input  wire  [DATA_WIDTH-1:0]      dma_wr_data,
  output logic                       dma_wr_ready,

  input  wire                        dma_rd_valid,
  input  wire  [DMEM_ADDR_WIDTH-1:0] dma_rd_addr,
  output logic                       dma_rd_ready,

  output logic                       dma_rd_resp_valid,
  output logic [DATA_WIDTH-1:0]      dma_rd_resp_data,
  input  wire                        dma_rd_resp_ready,

  input  wire                        core_en,
  input  wire                        core_wen,
  input  wire  [LANE_STRB-1:0]       core_strb,
  input  wire  [DMEM_ADDR_WIDTH-1:0] core_addr,
  input  wire  [LANE_WIDTH-1:0]      core_wdata,
  output logic [LANE_WIDTH-1:0]      core_rdata,
  output logic                       core_rd_valid,

  input  wire  [MSG_WIDTH-1:0]       msg,
  input  wire                        msg_valid
);

  logic                  rd_room;
  logic                  rd_data_valid;
  logic [DATA_WIDTH-1:0] rd_data;

  bank_req_if req_bus ();

  // Decode stage queues the DMA commands
  dma_cmd_decode decode0 (
    .clk         (clk),
    .rst         (rst),
    .dma_wr_valid(dma_wr_valid),
    .dma_wr_addr (dma_wr_addr),
    .dma_wr_strb (dma_wr_strb),
    .dma_wr_data (dma_wr_data),
    .dma_wr_ready(dma_wr_ready),
    .dma_rd_valid(dma_rd_valid),
    .dma_rd_addr (dma_rd_addr),
    .dma_rd_ready(dma_rd_ready),
    .req         (req_bus.decode)
  );

  // Execute stage owns the banks and their arbitration
  bank_execute execute0 (
    .clk          (clk),
    .rst          (rst),
    .msg          (msg),
    .msg_valid    (msg_valid),
    .core_en      (core_en),
    .core_wen     (core_wen),
    .core_strb    (core_strb),
    .core_addr    (core_addr),
    .core_wdata   (core_wdata),
    .core_rdata   (core_rdata),
    .core_rd_valid(core_rd_valid),
    .req          (req_bus.execute),
    .rd_room      (rd_room),
    .rd_data_valid(rd_data_valid),
    .rd_data      (rd_data)
  );

  read_result result0 (
    .clk              (clk),
    .rst              (rst),
    .rd_data_valid    (rd_data_valid),
    .rd_data          (rd_data),
    .rd_room          (rd_room),
    .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data (dma_rd_resp_data),
    .dma_rd_resp_ready(dma_rd_resp_ready)
  );

endmodule

`default_nettype wire

// ==== test/dmem_model.svh ====
`ifndef DMEM_MODEL_SVH
`define DMEM_MODEL_SVH

// Byte image of data memory. Every write the DUT accepts is applied here
// in the order the DUT applies it
logic [7:0] model_mem [DMEM_SIZE];

// Strobed write of a whole line that ignores the byte offset of addr
function automatic void model_write_line(
  input logic [DMEM_ADDR_WIDTH-1:0] addr,
  input logic [STRB_WIDTH-1:0]      strb,
  input logic [DATA_WIDTH-1:0]      data
);
  int base;
  base = int'(addr) & ~(STRB_WIDTH - 1);
  for (int i = 0; i < STRB_WIDTH; i++) begin
    if (strb[i]) begin
      model_mem[base + i] = data[8*i +: 8];
    end
  end
endfunction

// Strobed write of one 32-bit word for core writes and messages
function automatic void model_write_word(
  input logic [DMEM_ADDR_WIDTH-1:0] addr,
  input logic [LANE_STRB-1:0]       strb,
  input logic [LANE_WIDTH-1:0]      data
);
  int base;
  base = int'(addr) & ~(LANE_STRB - 1);
  for (int i = 0; i < LANE_STRB; i++) begin
    if (strb[i]) begin
      model_mem[base + i] = data[8*i +: 8];
    end
  end
endfunction

// Expected line for a DMA read with the lowest address in the lowest byte
function automatic logic [DATA_WIDTH-1:0] ref_line(input logic [DMEM_ADDR_WIDTH-1:0] addr);
  logic [DATA_WIDTH-1:0] line;
  int                    base;
  base = int'(addr) & ~(STRB_WIDTH - 1);
  for (int i = 0; i < STRB_WIDTH; i++) begin
    line[8*i +: 8] = model_mem[base + i];
  end
  return line;
endfunction

// Expected word for a core read
function automatic logic [LANE_WIDTH-1:0] ref_word(input logic [DMEM_ADDR_WIDTH-1:0] addr);
  logic [LANE_WIDTH-1:0] word;
  int                    base;
  base = int'(addr) & ~(LANE_STRB - 1);
  for (int i = 0; i < LANE_STRB; i++) begin
    word[8*i +: 8] = model_mem[base + i];
  end
  return word;
endfunction

`endif

// ==== test/tb_dmem_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dmem_sys
  import dmem_pkg::*;
();

  localparam int N_LINES   = 16;
  localparam int N_BP_READ = 48;
  // Each test gets a rough cycle budget and the watchdog allows twice the total
  localparam int TIMEOUT_CYCLES = 2 * (20 + 120 + 160 + 260 + 300);

  logic                       clk;
  logic                       rst;
  logic                       dma_wr_valid;
  logic [DMEM_ADDR_WIDTH-1:0] dma_wr_addr;
  logic [STRB_WIDTH-1:0]      dma_wr_strb;
  logic [DATA_WIDTH-1:0]      dma_wr_data;
  logic                       dma_wr_ready;
  logic                       dma_rd_valid;
  logic [DMEM_ADDR_WIDTH-1:0] dma_rd_addr;
  logic                       dma_rd_ready;
  logic                       dma_rd_resp_valid;
  logic [DATA_WIDTH-1:0]      dma_rd_resp_data;
  logic                       dma_rd_resp_ready;
  logic                       core_en;
  logic                       core_wen;
  logic [LANE_STRB-1:0]       core_strb;
  logic [DMEM_ADDR_WIDTH-1:0] core_addr;
  logic [LANE_WIDTH-1:0]      core_wdata;
  logic [LANE_WIDTH-1:0]      core_rdata;
  logic                       core_rd_valid;
  logic [MSG_WIDTH-1:0]       msg;
  logic                       msg_valid;

  int unsigned cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          resp_count  = 0;
  int          tests_run   = 0;
  int          tests_failed = 0;
  bit          saw_rd_stall;
  bit          reads_done;

  logic [DMEM_ADDR_WIDTH-1:0] line_addr [N_LINES];
  logic [DATA_WIDTH-1:0]      dma_exp_q [$];
  logic [LANE_WIDTH-1:0]      core_exp_q [$];
  int unsigned                core_cyc_q [$];

  `include "dmem_model.svh"

  dmem_sys_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////
  // Checking

  task automatic check_value(
    input string                 name,
    input logic [DATA_WIDTH-1:0] actual,
    input logic [DATA_WIDTH-1:0] expected
  );
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Outputs are stable at the falling edge, so all compares happen there
  always @(negedge clk) begin : compare_outputs
    logic [DATA_WIDTH-1:0] exp_line;
    logic [LANE_WIDTH-1:0] exp_word;
    if (!rst) begin
      if (dma_rd_resp_valid && dma_rd_resp_ready) begin
        resp_count++;
        if (dma_exp_q.size() == 0) begin
          report_problem("a DMA read response arrived with no read outstanding");
        end else begin
          exp_line = dma_exp_q.pop_front();
          check_value("dma_rd_resp_data", dma_rd_resp_data, exp_line);
        end
      end
      if (core_cyc_q.size() != 0 && cycle_count == core_cyc_q[0] + 1) begin
        void'(core_cyc_q.pop_front());
        exp_word = core_exp_q.pop_front();
        if (!core_rd_valid) begin
          report_problem("core_rd_valid stayed low one cycle after a core read");
        end else begin
          check_value("core_rdata", DATA_WIDTH'(core_rdata), DATA_WIDTH'(exp_word));
        end
      end else if (core_rd_valid) begin
        report_problem("core_rd_valid was high without a core read the cycle before");
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic dma_write(
    input logic [DMEM_ADDR_WIDTH-1:0] addr,
    input logic [STRB_WIDTH-1:0]      strb,
    input logic [DATA_WIDTH-1:0]      data
  );
    logic accepted;
    dma_wr_valid = 1'b1;
    dma_wr_addr  = addr;
    dma_wr_strb  = strb;
    dma_wr_data  = data;
    do begin
      @(negedge clk);
      accepted = dma_wr_ready;
      next_cycle();
    end while (!accepted);
    dma_wr_valid = 1'b0;
    model_write_line(addr, strb, data);
  endtask

  task automatic dma_read(input logic [DMEM_ADDR_WIDTH-1:0] addr);
    logic accepted;
    dma_rd_valid = 1'b1;
    dma_rd_addr  = addr;
    do begin
      @(negedge clk);
      accepted = dma_rd_ready;
      if (!accepted) begin
        saw_rd_stall = 1'b1;
      end
      next_cycle();
    end while (!accepted);
    dma_rd_valid = 1'b0;
    dma_exp_q.push_back(ref_line(addr));
  endtask

  task automatic core_write(
    input logic [DMEM_ADDR_WIDTH-1:0] addr,
    input logic [LANE_STRB-1:0]       strb,
    input logic [LANE_WIDTH-1:0]      data
  );
    core_en    = 1'b1;
    core_wen   = 1'b1;
    core_addr  = addr;
    core_strb  = strb;
    core_wdata = data;
    model_write_word(addr, strb, data);
    next_cycle();
    core_en = 1'b0;
  endtask

  task automatic core_read(input logic [DMEM_ADDR_WIDTH-1:0] addr);
    core_en   = 1'b1;
    core_wen  = 1'b0;
    core_addr = addr;
    core_exp_q.push_back(ref_word(addr));
    core_cyc_q.push_back(cycle_count);
    next_cycle();
    core_en = 1'b0;
  endtask

  task automatic wait_responses_drained();
    while (dma_exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
    end
    $display("Test %0d %s done, %0d errors", tests_run, name, error_count - errors_before);
  endtask

  //////////////////////////////
  // Tests

  task automatic test_reset_values();
    @(negedge clk);
    check_value("dma_rd_resp_valid", DATA_WIDTH'(dma_rd_resp_valid), 0);
    check_value("core_rd_valid", DATA_WIDTH'(core_rd_valid), 0);
    check_value("dma_wr_ready", DATA_WIDTH'(dma_wr_ready), 1);
    check_value("dma_rd_ready", DATA_WIDTH'(dma_rd_ready), 1);
    next_cycle();
  endtask

  task automatic test_dma_write_read();
    // Full lines first so that no byte read later is undefined
    for (int i = 0; i < N_LINES; i++) begin
      dma_write(line_addr[i], '1, {$urandom, $urandom});
    end
    for (int i = 0; i < N_LINES; i++) begin
      dma_write(line_addr[i], STRB_WIDTH'($urandom), {$urandom, $urandom});
    end
    repeat (8) next_cycle();
    for (int i = 0; i < N_LINES; i++) begin
      dma_read(line_addr[i]);
    end
    wait_responses_drained();
  endtask

  task automatic test_core_lanes();
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    for (int k = 0; k < 32; k++) begin
      addr = line_addr[$urandom % N_LINES] + DMEM_ADDR_WIDTH'(4 * ($urandom % 2));
      core_write(addr, LANE_STRB'($urandom), $urandom);
      core_read(addr);
    end
    next_cycle();
    for (int i = 0; i < N_LINES; i++) begin
      dma_read(line_addr[i]);
    end
    wait_responses_drained();
  endtask

  task automatic test_broadcast();
    logic [MSG_ADDR_WIDTH-1:0]  idx;
    logic [LANE_STRB-1:0]       strb;
    logic [LANE_WIDTH-1:0]      data;
    logic [DMEM_ADDR_WIDTH-1:0] bc_addr;
    // The whole region gets known contents through the core port
    for (int w = 0; w < BC_REGION_SIZE / 4; w++) begin
      core_write(DMEM_ADDR_WIDTH'(BC_START_ADDR + 4 * w), '1, $urandom);
    end
    for (int m = 0; m < 24; m++) begin
      idx       = MSG_ADDR_WIDTH'($urandom);
      strb      = LANE_STRB'($urandom);
      data      = $urandom;
      bc_addr   = DMEM_ADDR_WIDTH'(BC_START_ADDR + 4 * idx);
      msg       = {idx, strb, data};
      msg_valid = 1'b1;
      model_write_word(bc_addr, strb, data);
      next_cycle();
      msg_valid = 1'b0;
      dma_write(line_addr[$urandom % N_LINES], STRB_WIDTH'($urandom), {$urandom, $urandom});
      core_read(bc_addr);
    end
    repeat (8) next_cycle();
  endtask

  task automatic test_back_pressure();
    int resp_before;
    resp_before  = resp_count;
    saw_rd_stall = 1'b0;
    reads_done   = 1'b0;
    fork
      begin
        for (int r = 0; r < N_BP_READ; r++) begin
          dma_read(line_addr[$urandom % N_LINES]);
        end
        reads_done = 1'b1;
      end
      begin
        while (!reads_done || dma_exp_q.size() != 0) begin
          dma_rd_resp_ready = ($urandom % 3 == 0);
          next_cycle();
        end
        dma_rd_resp_ready = 1'b1;
      end
    join
    // Any duplicate response would show up during these cycles
    repeat (8) next_cycle();
    check_value("dma response count", DATA_WIDTH'(resp_count - resp_before), N_BP_READ);
    if (!saw_rd_stall) begin
      report_problem("dma_rd_ready never dropped while responses were held back");
    end
  endtask

  //////////////////////////////
  // Main sequence

  initial begin : main
    int errors_before;
    void'($urandom(94819));
    rst               = 1'b1;
    dma_wr_valid      = 1'b0;
    dma_wr_addr       = '0;
    dma_wr_strb       = '0;
    dma_wr_data       = '0;
    dma_rd_valid      = 1'b0;
    dma_rd_addr       = '0;
    dma_rd_resp_ready = 1'b1;
    core_en           = 1'b0;
    core_wen          = 1'b0;
    core_strb         = '0;
    core_addr         = '0;
    core_wdata        = '0;
    msg               = '0;
    msg_valid         = 1'b0;

    // Test lines sit below the broadcast region and alternate between banks
    for (int i = 0; i < N_LINES; i++) begin
      line_addr[i] = DMEM_ADDR_WIDTH'((($urandom % 224) * 2 + i % 2) * STRB_WIDTH);
    end

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    errors_before = error_count;
    test_reset_values();
    finish_test("reset values", errors_before);

    errors_before = error_count;
    test_dma_write_read();
    finish_test("DMA write and read", errors_before);

    errors_before = error_count;
    test_core_lanes();
    finish_test("core lanes", errors_before);

    errors_before = error_count;
    test_broadcast();
    finish_test("broadcast messages", errors_before);

    errors_before = error_count;
    test_back_pressure();
    finish_test("read back-pressure", errors_before);

    $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+test
src/dmem_pkg.sv
src/bank_req_if.sv
src/req_fifo.sv
src/dma_cmd_decode.sv
src/dmem_bank.sv
src/bank_execute.sv
src/read_result.sv
src/dmem_sys_top.sv
test/tb_dmem_sys.sv
